// ==== design/router_defs.svh ====
/* Router sizing macros */

`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Flits held by each input buffer
`define ROUTER_FIFO_DEPTH 4

// Downstream slots an output may fill after reset
`define ROUTER_CREDITS `ROUTER_FIFO_DEPTH

// Bits per mesh coordinate
`define ROUTER_COORD_W 3

`endif

// ==== design/router_pkg.sv ====
/* Router shared types */

`include "router_defs.svh"

package router_pkg;

  localparam int NUM_PORTS = 4;

  typedef enum logic [1:0] {
    FLIT_HEAD   = 2'b00,
    FLIT_BODY   = 2'b01,
    FLIT_TAIL   = 2'b10,
    FLIT_SINGLE = 2'b11
  } flit_kind_e;

  // Port index, also the value of a route
  typedef enum logic [1:0] {
    PORT_S = 2'd0,
    PORT_W = 2'd1,
    PORT_E = 2'd2,
    PORT_L = 2'd3
  } port_e;

  typedef struct packed {
    flit_kind_e                  kind;
    logic [`ROUTER_COORD_W-1:0]  dest_y;
    logic [`ROUTER_COORD_W-1:0]  dest_x;
    logic [7:0]                  tag;
  } head_flit_t;

  typedef struct packed {
    flit_kind_e  kind;
    logic [13:0] payload;
  } body_flit_t;

  // Kind sits in the same bits in both views
  typedef union packed {
    head_flit_t head;
    body_flit_t body;
  } flit_u;

  typedef struct packed {
    logic  valid;
    flit_u flit;
  } link_t;

  typedef struct packed {
    logic [`ROUTER_COORD_W-1:0] y;
    logic [`ROUTER_COORD_W-1:0] x;
  } coord_t;

endpackage

// ==== design/input_buffer.sv ====
/* Input flit FIFO */

`timescale 1ns/10ps

`include "router_defs.svh"

module input_buffer #(
  parameter int DEPTH = `ROUTER_FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              reset_i,
  input  router_pkg::link_t link_i,
  input  logic              read_i,
  output router_pkg::link_t head_o,
  output logic              credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  router_pkg::flit_u mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_en;
  logic             rd_en;

  assign wr_en = link_i.valid;
  assign rd_en = read_i && (count_q != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= link_i.flit;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o.valid = (count_q != '0);
  assign head_o.flit  = mem[rd_ptr_q];

  // One credit back upstream per flit that leaves
  assign credit_o = rd_en;

endmodule

// ==== design/route_unit.sv ====
/* YX route computation */

`timescale 1ns/10ps

module route_unit (
  input  logic               clk,
  input  logic               reset_i,
  input  router_pkg::link_t  head_i,
  input  logic               read_i,
  input  router_pkg::coord_t router_addr_i,
  output logic               req_valid_o,
  output router_pkg::port_e  req_port_o
);

  router_pkg::flit_kind_e kind;
  router_pkg::port_e      route_comb;
  router_pkg::port_e      route_q;
  logic                   route_vld_q;
  logic                   pkt_start;

  assign kind      = head_i.flit.head.kind;
  assign pkt_start = (kind == router_pkg::FLIT_HEAD) || (kind == router_pkg::FLIT_SINGLE);

  // Y first (south grows), then X
  always_comb begin
    if (head_i.flit.head.dest_y > router_addr_i.y) begin
      route_comb = router_pkg::PORT_S;
    end else if (head_i.flit.head.dest_x < router_addr_i.x) begin
      route_comb = router_pkg::PORT_W;
    end else if (head_i.flit.head.dest_x > router_addr_i.x) begin
      route_comb = router_pkg::PORT_E;
    end else begin
      route_comb = router_pkg::PORT_L;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      route_vld_q <= 1'b0;
      route_q     <= router_pkg::PORT_S;
    end else if (read_i && head_i.valid) begin
      if (!route_vld_q && kind == router_pkg::FLIT_HEAD) begin
        route_vld_q <= 1'b1;
        route_q     <= route_comb;
      end else if (route_vld_q && kind == router_pkg::FLIT_TAIL) begin
        route_vld_q <= 1'b0;
      end
    end
  end

  assign req_valid_o = head_i.valid && (route_vld_q || pkt_start);
  assign req_port_o  = route_vld_q ? route_q : route_comb;

endmodule

// ==== design/credit_counter.sv ====
/* Output credit counter */

`timescale 1ns/10ps

`include "router_defs.svh"

module credit_counter #(
  parameter int CREDITS = `ROUTER_CREDITS
) (
  input  logic clk,
  input  logic reset_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic has_credit_o
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  // Free slots in the downstream buffer
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= CNT_W'(CREDITS);
    end else begin
      case ({inc_i, dec_i})
        2'b10: begin
          if (count_q != CNT_W'(CREDITS)) count_q <= count_q + 1'b1;
        end
        2'b01: begin
          if (count_q != '0) count_q <= count_q - 1'b1;
        end
        default: count_q <= count_q;
      endcase
    end
  end

  assign has_credit_o = (count_q != '0);

endmodule

// ==== design/wormhole_arbiter.sv ====
/* Wormhole round-robin arbiter */

`timescale 1ns/10ps

module wormhole_arbiter (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  logic [router_pkg::NUM_PORTS-1:0]           req_i,
  input  router_pkg::link_t [router_pkg::NUM_PORTS-1:0] head_i,
  input  logic                                       has_credit_i,
  output logic [router_pkg::NUM_PORTS-1:0]           grant_o,
  output logic                                       send_o
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } arb_state_e;

  arb_state_e        state_q;
  arb_state_e        state_d;
  router_pkg::port_e lock_q;
  router_pkg::port_e lock_d;
  router_pkg::port_e last_q;
  router_pkg::port_e last_d;
  router_pkg::port_e pick;
  logic              pick_found;
  logic [1:0]        scan_idx;

  function automatic logic is_tail(router_pkg::link_t l);
    return (l.flit.body.kind == router_pkg::FLIT_TAIL) ||
           (l.flit.body.kind == router_pkg::FLIT_SINGLE);
  endfunction

  // First requester after the last winner
  always_comb begin
    pick_found = 1'b0;
    pick       = last_q;
    scan_idx   = '0;
    for (int k = 1; k <= router_pkg::NUM_PORTS; k++) begin
      scan_idx = 2'(int'(last_q) + k);
      if (!pick_found && req_i[scan_idx]) begin
        pick_found = 1'b1;
        pick       = router_pkg::port_e'(scan_idx);
      end
    end
  end

  always_comb begin
    grant_o = '0;
    send_o  = 1'b0;
    state_d = state_q;
    lock_d  = lock_q;
    last_d  = last_q;
    case (state_q)
      ST_IDLE: begin
        if (pick_found && has_credit_i) begin
          grant_o[pick] = 1'b1;
          send_o        = 1'b1;
          if (is_tail(head_i[pick])) begin
            last_d = pick;
          end else begin
            state_d = ST_BUSY;
            lock_d  = pick;
          end
        end
      end
      ST_BUSY: begin
        // Grant held for the whole packet, even while stalled
        grant_o[lock_q] = 1'b1;
        if (head_i[lock_q].valid && has_credit_i) begin
          send_o = 1'b1;
          if (is_tail(head_i[lock_q])) begin
            state_d = ST_IDLE;
            last_d  = lock_q;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      lock_q  <= router_pkg::PORT_S;
      last_q  <= router_pkg::PORT_L;
    end else begin
      state_q <= state_d;
      lock_q  <= lock_d;
      last_q  <= last_d;
    end
  end

endmodule

// ==== design/crossbar.sv ====
/* Registered crossbar */

`timescale 1ns/10ps

module crossbar (
  input  logic                                               clk,
  input  logic                                               reset_i,
  input  router_pkg::link_t [router_pkg::NUM_PORTS-1:0]         head_i,
  input  logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_PORTS-1:0] grant_i,
  input  logic [router_pkg::NUM_PORTS-1:0]                   send_i,
  output router_pkg::link_t [router_pkg::NUM_PORTS-1:0]         out_link_o
);

  localparam int N = router_pkg::NUM_PORTS;

  logic [N-1:0][15:0]            sel_flit;
  logic [N-1:0]                  valid_q;
  router_pkg::flit_u [N-1:0]     data_q;

  // AND-OR mux, grant_i is [output][input]
  always_comb begin
    for (int o = 0; o < N; o++) begin
      sel_flit[o] = '0;
      for (int i = 0; i < N; i++) begin
        sel_flit[o] = sel_flit[o] | (head_i[i].flit & {16{grant_i[o][i]}});
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= send_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < N; o++) begin
      if (send_i[o]) data_q[o] <= sel_flit[o];
    end
  end

  always_comb begin
    for (int o = 0; o < N; o++) begin
      out_link_o[o].valid = valid_q[o];
      out_link_o[o].flit  = data_q[o];
    end
  end

endmodule

// ==== design/n_edge_router.sv ====
/* North-edge mesh router */

`timescale 1ns/10ps

module n_edge_router (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  router_pkg::coord_t                            yx_addr_router_i,
  input  router_pkg::link_t [router_pkg::NUM_PORTS-1:0] in_link_i,
  input  logic [router_pkg::NUM_PORTS-1:0]              credit_i,
  output router_pkg::link_t [router_pkg::NUM_PORTS-1:0] out_link_o,
  output logic [router_pkg::NUM_PORTS-1:0]              credit_o
);

  localparam int N = router_pkg::NUM_PORTS;

  router_pkg::link_t [N-1:0] ib_head;
  logic [N-1:0]              ib_read;
  logic [N-1:0]              rt_req_valid;
  router_pkg::port_e [N-1:0] rt_req_port;
  logic [N-1:0]              has_credit;
  logic [N-1:0]              arb_send;
  logic [N-1:0][N-1:0]       arb_req;     // [output][input]
  logic [N-1:0][N-1:0]       arb_grant;   // [output][input]
  logic [N-1:0][N-1:0]       grant_sent;  // [input][output]

  for (genvar i = 0; i < N; i++) begin : g_in
    input_buffer u_ib (
      .clk      (clk),
      .reset_i  (reset_i),
      .link_i   (in_link_i[i]),
      .read_i   (ib_read[i]),
      .head_o   (ib_head[i]),
      .credit_o (credit_o[i])
    );

    route_unit u_rt (
      .clk           (clk),
      .reset_i       (reset_i),
      .head_i        (ib_head[i]),
      .read_i        (ib_read[i]),
      .router_addr_i (yx_addr_router_i),
      .req_valid_o   (rt_req_valid[i]),
      .req_port_o    (rt_req_port[i])
    );

    for (genvar o = 0; o < N; o++) begin : g_xp
      assign arb_req[o][i]    = rt_req_valid[i] && (rt_req_port[i] == router_pkg::port_e'(o));
      assign grant_sent[i][o] = arb_grant[o][i] && arb_send[o];
    end

    // Pop when any output sends this input's flit
    assign ib_read[i] = |grant_sent[i];
  end

  for (genvar o = 0; o < N; o++) begin : g_out
    credit_counter u_cc (
      .clk          (clk),
      .reset_i      (reset_i),
      .inc_i        (credit_i[o]),
      .dec_i        (arb_send[o]),
      .has_credit_o (has_credit[o])
    );

    wormhole_arbiter u_arb (
      .clk          (clk),
      .reset_i      (reset_i),
      .req_i        (arb_req[o]),
      .head_i       (ib_head),
      .has_credit_i (has_credit[o]),
      .grant_o      (arb_grant[o]),
      .send_o       (arb_send[o])
    );
  end

  crossbar u_xbar (
    .clk        (clk),
    .reset_i    (reset_i),
    .head_i     (ib_head),
    .grant_i    (arb_grant),
    .send_i     (arb_send),
    .out_link_o (out_link_o)
  );

endmodule

// ==== dv/router_asserts.sv ====
/* Router bound assertions */

`timescale 1ns/10ps

`include "router_defs.svh"

module router_asserts (
  input logic                                                     clk_i,
  input logic                                                     reset_i,
  input router_pkg::link_t [router_pkg::NUM_PORTS-1:0]            in_link_i,
  input logic [router_pkg::NUM_PORTS-1:0]                         read_i,
  input logic [router_pkg::NUM_PORTS-1:0]                         credit_i,
  input logic [router_pkg::NUM_PORTS-1:0]                         send_i,
  input logic [router_pkg::NUM_PORTS-1:0]                         has_credit_i,
  input logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_PORTS-1:0] grant_i
);

  localparam int N = router_pkg::NUM_PORTS;

  // Shadow buffer fill and output credits
  logic [N-1:0][3:0] fill_q;
  logic [N-1:0][3:0] credits_q;

  // Grants turned to [input][output]
  logic [N-1:0][N-1:0] grant_by_in;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      for (int o = 0; o < N; o++) begin
        grant_by_in[i][o] = grant_i[o][i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < N; p++) begin
      if (reset_i) begin
        fill_q[p]    <= '0;
        credits_q[p] <= 4'(`ROUTER_CREDITS);
      end else begin
        fill_q[p]    <= fill_q[p] + 4'(in_link_i[p].valid) - 4'(read_i[p]);
        credits_q[p] <= credits_q[p] + 4'(credit_i[p]) - 4'(send_i[p]);
      end
    end
  end

  for (genvar p = 0; p < N; p++) begin : g_chk
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(grant_by_in[p]))
      else $error("input %0d granted by more than one output", p);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
      in_link_i[p].valid |-> fill_q[p] < 4'(`ROUTER_FIFO_DEPTH))
      else $error("input buffer %0d written while full", p);

    a_send_credit: assert property (@(posedge clk_i) disable iff (reset_i)
      send_i[p] |-> credits_q[p] != '0)
      else $error("output %0d sent without credit", p);

    a_credit_track: assert property (@(posedge clk_i) disable iff (reset_i)
      has_credit_i[p] == (credits_q[p] != '0))
      else $error("output %0d credit counter disagrees with returned credits", p);
  end

endmodule

bind n_edge_router router_asserts u_asserts (
  .clk_i        (clk),
  .reset_i      (reset_i),
  .in_link_i    (in_link_i),
  .read_i       (ib_read),
  .credit_i     (credit_i),
  .send_i       (arb_send),
  .has_credit_i (has_credit),
  .grant_i      (arb_grant)
);

// ==== dv/router_tb.sv ====
/* Router testbench */

`timescale 1ns/10ps

`include "router_defs.svh"

module router_tb;

  localparam int N_PKT      = 12;
  localparam int N_FAIR     = 6;
  localparam int TOTAL_PKTS = 4 * N_PKT + 2 * N_FAIR;
  localparam int OWN_Y      = 0;
  localparam int OWN_X      = 3;

  logic                     clk;
  logic                     reset;
  router_pkg::coord_t       own_addr;
  router_pkg::link_t [3:0]  in_link;
  logic [3:0]               credit_in;
  router_pkg::link_t [3:0]  out_link;
  logic [3:0]               credit_out;

  logic [15:0]        lfsr;
  router_pkg::flit_u  src_q [4][$];
  router_pkg::flit_u  exp_q [4][4][$];
  int                 up_credit [4];
  int                 injected [4];
  int                 credit_pulses [4];
  int                 pending [4];
  int                 received [4];
  int                 returned [4];
  int                 cur_src [4];
  logic               in_pkt [4];
  logic [3:0]         hold;
  int                 fair_seq [$];
  logic               run;
  logic               fair_on;
  int                 errors;
  int                 checks;

  n_edge_router uut (
    .clk              (clk),
    .reset_i          (reset),
    .yx_addr_router_i (own_addr),
    .in_link_i        (in_link),
    .credit_i         (credit_in),
    .out_link_o       (out_link),
    .credit_o         (credit_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(TOTAL_PKTS * 4 * 40 * 100);
    $display("ERROR: watchdog timeout, traffic did not drain in time");
    $display("RESULT: FAIL");
    $finish;
  end

  // Galois LFSR, one step per bit
  function automatic int next_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic int yx_route(input int dy, input int dx);
    if (dy > OWN_Y) return int'(router_pkg::PORT_S);
    if (dx < OWN_X) return int'(router_pkg::PORT_W);
    if (dx > OWN_X) return int'(router_pkg::PORT_E);
    return int'(router_pkg::PORT_L);
  endfunction

  // Any port but the entry one
  function automatic int pick_port(input int src);
    int p;
    p = next_bits(2);
    while (p == src) begin
      p = next_bits(2);
    end
    return p;
  endfunction

  function automatic logic drained();
    int n;
    n = 0;
    for (int i = 0; i < 4; i++) begin
      n += src_q[i].size();
      for (int o = 0; o < 4; o++) begin
        n += exp_q[o][i].size();
      end
    end
    return n == 0;
  endfunction

  function automatic int out_valids();
    int v;
    v = 0;
    for (int o = 0; o < 4; o++) begin
      v |= int'(out_link[o].valid) << o;
    end
    return v;
  endfunction

  task automatic check_flit(input string name, input router_pkg::flit_u exp,
                            input router_pkg::flit_u act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Tag and payload carry the source input in their top bits
  task automatic make_packet(input int src, input int port);
    router_pkg::flit_u f;
    int len;
    int dy;
    int dx;
    int route;
    len = next_bits(2) + 1;
    case (port)
      0: begin
        dy = 1 + next_bits(3) % 7;
        dx = next_bits(3);
      end
      1: begin
        dy = 0;
        dx = next_bits(3) % 3;
      end
      2: begin
        dy = 0;
        dx = 4 + next_bits(2);
      end
      default: begin
        dy = 0;
        dx = 3;
      end
    endcase
    route = yx_route(dy, dx);
    for (int k = 0; k < len; k++) begin
      if (k == 0) begin
        f.head.kind   = (len == 1) ? router_pkg::FLIT_SINGLE : router_pkg::FLIT_HEAD;
        f.head.dest_y = 3'(dy);
        f.head.dest_x = 3'(dx);
        f.head.tag    = {2'(src), 6'(next_bits(6))};
      end else begin
        f.body.kind    = (k == len - 1) ? router_pkg::FLIT_TAIL : router_pkg::FLIT_BODY;
        f.body.payload = {2'(src), 12'(next_bits(12))};
      end
      src_q[src].push_back(f);
      exp_q[route][src].push_back(f);
    end
  endtask

  task automatic track_flit(input int o, input router_pkg::flit_u f);
    int   src;
    logic starts;
    starts = (f.head.kind == router_pkg::FLIT_HEAD) || (f.head.kind == router_pkg::FLIT_SINGLE);
    src    = starts ? int'(f.head.tag[7:6]) : cur_src[o];
    if (starts && in_pkt[o]) begin
      errors++;
      $display("ERROR: output %0d started a packet before the previous one ended", o);
    end
    if (!starts && !in_pkt[o]) begin
      errors++;
      $display("ERROR: output %0d sent a body flit outside any packet", o);
    end else if (exp_q[o][src].size() == 0) begin
      errors++;
      $display("ERROR: output %0d sent a flit not expected from input %0d", o, src);
    end else begin
      check_flit(starts ? "packet_head" : "packet_body", exp_q[o][src].pop_front(), f);
    end
    if (starts) begin
      cur_src[o] = src;
    end
    in_pkt[o] = (f.head.kind == router_pkg::FLIT_HEAD) || (f.head.kind == router_pkg::FLIT_BODY);
    if (starts && fair_on && o == int'(router_pkg::PORT_L)) begin
      fair_seq.push_back(src);
    end
  endtask

  // Upstream senders, output monitor and downstream sinks
  always @(posedge clk) begin
    router_pkg::link_t lk;
    if (reset) begin
      in_link   <= '0;
      credit_in <= '0;
    end else begin
      for (int p = 0; p < 4; p++) begin
        if (credit_out[p]) begin
          up_credit[p]++;
          credit_pulses[p]++;
          if (up_credit[p] > `ROUTER_CREDITS) begin
            errors++;
            $display("ERROR: input %0d returned more credits than were used", p);
          end
        end
        if (run && up_credit[p] > 0 && src_q[p].size() > 0) begin
          lk.valid = 1'b1;
          lk.flit  = src_q[p].pop_front();
          in_link[p] <= lk;
          up_credit[p]--;
          injected[p]++;
        end else begin
          in_link[p] <= '0;
        end
        if (out_link[p].valid) begin
          received[p]++;
          pending[p]++;
          if (received[p] > `ROUTER_CREDITS + returned[p]) begin
            errors++;
            $display("ERROR: output %0d sent more flits than its credits allow", p);
          end
          track_flit(p, out_link[p].flit);
        end
        credit_in[p] <= 1'b0;
        if (pending[p] > 0 && !hold[p]) begin
          if (next_bits(2) != 0) begin
            credit_in[p] <= 1'b1;
            pending[p]--;
            returned[p]++;
          end
        end
      end
    end
  end

  initial begin
    lfsr      = 16'd34;
    reset     = 1'b1;
    own_addr  = '{y: 3'(OWN_Y), x: 3'(OWN_X)};
    in_link   = '0;
    credit_in = '0;
    hold      = '0;
    run       = 1'b0;
    fair_on   = 1'b0;
    errors    = 0;
    checks    = 0;
    for (int p = 0; p < 4; p++) begin
      up_credit[p]     = `ROUTER_CREDITS;
      injected[p]      = 0;
      credit_pulses[p] = 0;
      pending[p]       = 0;
      received[p]      = 0;
      returned[p]      = 0;
      cur_src[p]       = 0;
      in_pkt[p]        = 1'b0;
    end
    for (int k = 0; k < N_PKT; k++) begin
      for (int p = 0; p < 4; p++) begin
        make_packet(p, pick_port(p));
      end
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_count("reset_out_valid", 0, out_valids());
      check_count("reset_credit_o", 0, int'(credit_out));
    end
    // East sink withholds credits at first
    hold[router_pkg::PORT_E] = 1'b1;
    run = 1'b1;
    repeat (300) @(negedge clk);
    hold = '0;
    while (!drained()) @(negedge clk);
    // South and west contend for the local port
    fair_on = 1'b1;
    for (int k = 0; k < N_FAIR; k++) begin
      make_packet(int'(router_pkg::PORT_S), int'(router_pkg::PORT_L));
      make_packet(int'(router_pkg::PORT_W), int'(router_pkg::PORT_L));
    end
    while (!drained()) @(negedge clk);
    check_count("fair_packets", 2 * N_FAIR, fair_seq.size());
    for (int k = 1; k < fair_seq.size(); k++) begin
      if (fair_seq[k] == fair_seq[k-1]) begin
        errors++;
        $display("ERROR: local port served input %0d twice in a row", fair_seq[k]);
      end
    end
    for (int p = 0; p < 4; p++) begin
      check_count("credit_return", injected[p], credit_pulses[p]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+design
design/router_pkg.sv
design/input_buffer.sv
design/route_unit.sv
design/credit_counter.sv
design/wormhole_arbiter.sv
design/crossbar.sv
design/n_edge_router.sv
dv/router_asserts.sv
dv/router_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module router_tb -Mdir obj_dir \
  && ./obj_dir/Vrouter_tb 2>&1 | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }
grep -q "RESULT: FAIL" sim.log \
  && { echo "Simulation reported failure"; exit 1; } \
  || { echo "Simulation finished without failure"; exit 0; }
